//--- Makefile
# Verilator build and run of the TAP testbench

all: run

compile:
	verilator --binary --assert -j 0 --top-module stap_tb -f stap.f -o stap_tb

# Pass or fail comes from the pass message in the simulation output
run: compile
	@out=$$(./obj_dir/stap_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- stap.f
verilog/stap_pkg.sv
verilog/stap_fsm.sv
verilog/stap_ir.sv
verilog/stap_dr.sv
verilog/stap.sv
verif/stap_checker.sv
verif/stap_tb.sv

//--- verif/stap_checker.sv
/*
 * Reference TAP model for the testbench
 * Tracks state, IR and DR images from the pins, compares DUT outputs
 */

module stap_checker
    import stap_pkg::*;
(
    input  logic    ftap_tck,
    input  logic    rst_n,
    input  logic    ftap_tms,
    input  logic    ftap_tdi,
    input  idcode_t ftap_slvidcode,
    input  tdr_t    tdr_data_in,
    input  logic    atap_tdo,
    input  logic    atap_tdoen,
    input  logic    tap_rti,
    input  tdr_t    tdr_data_out,
    output int      error_count
);

    string               test_name = "reset";
    int                  errors = 0;
    logic                valid = 1'b0;
    tap_state_e          state = st_tlr;
    logic [ir_width-1:0] ir_img = '0;
    logic [ir_width-1:0] ir_op = op_idcode;
    idcode_t             id_img = '0;
    tdr_t                tdr_img = '0;
    tdr_t                tdr_out = '0;
    logic                byp_img = 1'b0;

    assign error_count = errors;

    // 1149.1 state graph
    function automatic tap_state_e next_state(tap_state_e s, logic tms);
        case (s)
            st_tlr:      return tms ? st_tlr      : st_rti;
            st_rti:      return tms ? st_sel_dr   : st_rti;
            st_sel_dr:   return tms ? st_sel_ir   : st_cap_dr;
            st_cap_dr:   return tms ? st_exit1_dr : st_shift_dr;
            st_shift_dr: return tms ? st_exit1_dr : st_shift_dr;
            st_exit1_dr: return tms ? st_upd_dr   : st_pause_dr;
            st_pause_dr: return tms ? st_exit2_dr : st_pause_dr;
            st_exit2_dr: return tms ? st_upd_dr   : st_shift_dr;
            st_sel_ir:   return tms ? st_tlr      : st_cap_ir;
            st_cap_ir:   return tms ? st_exit1_ir : st_shift_ir;
            st_shift_ir: return tms ? st_exit1_ir : st_shift_ir;
            st_exit1_ir: return tms ? st_upd_ir   : st_pause_ir;
            st_pause_ir: return tms ? st_exit2_ir : st_pause_ir;
            st_exit2_ir: return tms ? st_upd_ir   : st_shift_ir;
            // Update-DR and Update-IR share successors
            default:     return tms ? st_sel_dr   : st_rti;
        endcase
    endfunction

    task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED test=%s %s expected=%h actual=%h",
                     test_name, what, exp, act);
        end
    endtask

    // ------------------------------
    // Model update on TCK
    // ------------------------------
    // All images capture and shift, only the selected one is ever observed
    always @(posedge ftap_tck) begin
        if (!rst_n) begin
            state   = st_tlr;
            ir_op   = op_idcode;
            tdr_out = '0;
            valid   = 1'b1;
        end else begin
            case (state)
                st_tlr:      ir_op = op_idcode;
                st_cap_ir:   ir_img = ir_capture_value;
                st_shift_ir: ir_img = {ftap_tdi, ir_img[ir_width-1:1]};
                st_upd_ir:   ir_op = ir_img;
                st_cap_dr: begin
                    id_img  = ftap_slvidcode;
                    tdr_img = tdr_data_in;
                    byp_img = 1'b0;
                end
                st_shift_dr: begin
                    id_img  = {ftap_tdi, id_img[idcode_width-1:1]};
                    tdr_img = {ftap_tdi, tdr_img[tdr_width-1:1]};
                    byp_img = ftap_tdi;
                end
                st_upd_dr: if (ir_op == op_tdr) tdr_out = tdr_img;
                default: ;
            endcase
            state = next_state(state, ftap_tms);
        end
    end

    // ------------------------------
    // Output compare
    // ------------------------------
    // Falling edge, outputs have settled since the last rising edge
    always @(negedge ftap_tck) begin
        logic exp_tdo;
        logic in_shift;
        if (valid) begin
            in_shift = (state == st_shift_ir) || (state == st_shift_dr);
            if (state == st_shift_ir) exp_tdo = ir_img[0];
            else if (ir_op == op_idcode) exp_tdo = id_img[0];
            else if (ir_op == op_tdr) exp_tdo = tdr_img[0];
            else exp_tdo = byp_img;
            compare("atap_tdoen", 32'(in_shift), 32'(atap_tdoen));
            compare("tap_rti", 32'(state == st_rti), 32'(tap_rti));
            compare("tdr_data_out", 32'(tdr_out), 32'(tdr_data_out));
            if (in_shift) compare("atap_tdo", 32'(exp_tdo), 32'(atap_tdo));
        end
    end

endmodule

//--- verif/stap_tb.sv
/*
 * Testbench top for the TAP
 * Clock, reset, seeded random IR/DR scans and TMS walks
 * Watchdog and closing report
 */

module stap_tb
    import stap_pkg::*;
();

    // Longest operation is a walk plus reset plus IDCODE read, under 60 cycles
    localparam int num_random = 40;
    localparam int num_ops    = num_random + 8;
    localparam int timeout    = num_ops * 60 * 20 + 3 * 20;

    logic    ftap_tck = 1'b0;
    logic    rst_n;
    logic    ftap_tms;
    logic    ftap_tdi;
    idcode_t ftap_slvidcode;
    tdr_t    tdr_data_in;
    logic    atap_tdo;
    logic    atap_tdoen;
    logic    tap_rti;
    tdr_t    tdr_data_out;
    int      error_count;
    int      seed = 32'h4c08_e602;

    stap uut (.*);
    stap_checker i_checker (.*);

    always #10 ftap_tck = ~ftap_tck;

    // ------------------------------
    // JTAG sequences
    // ------------------------------
    // Called 2 units after an edge, values are sampled at the next edge
    task automatic tick(input logic tms, input logic tdi);
        ftap_tms = tms;
        ftap_tdi = tdi;
        @(posedge ftap_tck);
        #2;
    endtask

    // From Run-Test/Idle back to Run-Test/Idle, N+5 edges
    task automatic dr_scan(input int width, input logic [31:0] data);
        tick(1'b1, 1'b0);
        tick(1'b0, 1'b0);
        tick(1'b0, 1'b0);
        for (int i = 0; i < width; i++) begin
            tick(i == width - 1, data[i]);
        end
        tick(1'b1, 1'b0);
        tick(1'b0, 1'b0);
    endtask

    task automatic ir_scan(input logic [ir_width-1:0] op);
        tick(1'b1, 1'b0);
        tick(1'b1, 1'b0);
        tick(1'b0, 1'b0);
        tick(1'b0, 1'b0);
        for (int i = 0; i < ir_width; i++) begin
            tick(i == ir_width - 1, op[i]);
        end
        tick(1'b1, 1'b0);
        tick(1'b0, 1'b0);
    endtask

    // Five TMS-high edges, then park in Run-Test/Idle
    task automatic tms_reset();
        repeat (5) tick(1'b1, 1'b0);
        tick(1'b0, 1'b0);
    endtask

    // rst_n drops somewhere inside Shift-DR
    task automatic reset_mid_scan();
        tick(1'b1, 1'b0);
        tick(1'b0, 1'b0);
        tick(1'b0, 1'b0);
        repeat (1 + ($random(seed) & 7)) tick(1'b0, 1'($random(seed)));
        rst_n = 1'b0;
        tick(1'b0, 1'b0);
        rst_n = 1'b1;
        tick(1'b0, 1'b0);
    endtask

    task automatic random_op();
        int                  sel;
        logic [ir_width-1:0] op;
        tdr_data_in = tdr_t'($random(seed));
        sel = $random(seed) & 3;
        case (sel)
            0: begin
                i_checker.test_name = "random_ir_dr";
                sel = $random(seed) & 3;
                op  = (sel == 0) ? op_idcode : (sel == 1) ? op_tdr :
                      (sel == 2) ? op_bypass : 4'($random(seed));
                ir_scan(op);
                dr_scan(32, $random(seed));
            end
            1: begin
                i_checker.test_name = "random_dr";
                dr_scan(32, $random(seed));
            end
            2: begin
                // Free walk, then reset by TMS and confirm IDCODE
                i_checker.test_name = "tms_walk";
                repeat (1 + ($random(seed) & 15)) tick(1'($random(seed)), 1'($random(seed)));
                tms_reset();
                dr_scan(32, $random(seed));
            end
            default: begin
                i_checker.test_name = "mid_scan_reset";
                reset_mid_scan();
                dr_scan(32, $random(seed));
            end
        endcase
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n          = 1'b0;
        ftap_tms       = 1'b1;
        ftap_tdi       = 1'b0;
        ftap_slvidcode = idcode_t'($random(seed)) | 32'h1;
        tdr_data_in    = tdr_t'($random(seed));
        repeat (3) @(posedge ftap_tck);
        #2;
        rst_n = 1'b1;
        tick(1'b0, 1'b0);
        i_checker.test_name = "idcode_after_reset";
        dr_scan(32, $random(seed));
        i_checker.test_name = "tdr_write";
        ir_scan(op_tdr);
        dr_scan(tdr_width, $random(seed));
        i_checker.test_name = "bypass";
        ir_scan(op_bypass);
        dr_scan(8, $random(seed));
        i_checker.test_name = "tdr_read";
        tdr_data_in = tdr_t'($random(seed));
        ir_scan(op_tdr);
        dr_scan(tdr_width, $random(seed));
        i_checker.test_name = "tms_reset";
        tms_reset();
        dr_scan(32, $random(seed));
        repeat (num_random) random_op();
        $display("Done: %0d random operations, %0d errors", num_random, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout);
        $display("Watchdog expired after %0d time units, the scan sequence never finished",
                 timeout);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog/stap.sv
/*
 * TAP top level
 * Controller, instruction register, IDCODE and TDR registers
 * BYPASS bit, per-register strobe gating and TDO mux
 */

module stap
    import stap_pkg::*;
(
    input  logic    ftap_tck,
    input  logic    rst_n,
    input  logic    ftap_tms,
    input  logic    ftap_tdi,
    input  idcode_t ftap_slvidcode,
    input  tdr_t    tdr_data_in,
    output logic    atap_tdo,
    output logic    atap_tdoen,
    output logic    tap_rti,
    output tdr_t    tdr_data_out
);

    tap_ctrl_t tap_ctrl;
    dr_sel_t   dr_sel;
    logic      ir_tdo;
    logic      idcode_tdo;
    logic      tdr_tdo;
    logic      dr_tdo;
    logic      bypass_q;

    // ------------------------------
    // Controller and IR
    // ------------------------------
    stap_fsm i_fsm (
        .ftap_tck (ftap_tck),
        .rst_n    (rst_n),
        .ftap_tms (ftap_tms),
        .tap_ctrl (tap_ctrl)
    );

    stap_ir i_ir (
        .ftap_tck (ftap_tck),
        .rst_n    (rst_n),
        .tap_ctrl (tap_ctrl),
        .ftap_tdi (ftap_tdi),
        .ir_tdo   (ir_tdo),
        .dr_sel   (dr_sel)
    );

    // ------------------------------
    // Data registers
    // ------------------------------
    // IDCODE is read only, its update side goes nowhere
    stap_dr #(.payload_t(idcode_t)) i_idcode (
        .ftap_tck     (ftap_tck),
        .rst_n        (rst_n),
        .capture      (tap_ctrl.capture_dr & dr_sel.sel_idcode),
        .shift        (tap_ctrl.shift_dr & dr_sel.sel_idcode),
        .update       (tap_ctrl.update_dr & dr_sel.sel_idcode),
        .ftap_tdi     (ftap_tdi),
        .capture_data (ftap_slvidcode),
        .shift_tdo    (idcode_tdo),
        .update_data  ()
    );

    stap_dr #(.payload_t(tdr_t)) i_tdr (
        .ftap_tck     (ftap_tck),
        .rst_n        (rst_n),
        .capture      (tap_ctrl.capture_dr & dr_sel.sel_tdr),
        .shift        (tap_ctrl.shift_dr & dr_sel.sel_tdr),
        .update       (tap_ctrl.update_dr & dr_sel.sel_tdr),
        .ftap_tdi     (ftap_tdi),
        .capture_data (tdr_data_in),
        .shift_tdo    (tdr_tdo),
        .update_data  (tdr_data_out)
    );

    // BYPASS bit, captures 0 and then delays TDI by one edge
    always_ff @(posedge ftap_tck) begin
        if (tap_ctrl.capture_dr && dr_sel.sel_bypass) begin
            bypass_q <= 1'b0;
        end else if (tap_ctrl.shift_dr && dr_sel.sel_bypass) begin
            bypass_q <= ftap_tdi;
        end
    end

    // ------------------------------
    // TDO path
    // ------------------------------
    always_comb begin
        if (dr_sel.sel_idcode) begin
            dr_tdo = idcode_tdo;
        end else if (dr_sel.sel_tdr) begin
            dr_tdo = tdr_tdo;
        end else begin
            dr_tdo = bypass_q;
        end
    end

    // IR wins only in Shift-IR
    assign atap_tdo   = tap_ctrl.shift_ir ? ir_tdo : dr_tdo;
    assign atap_tdoen = tap_ctrl.shift_ir | tap_ctrl.shift_dr;
    assign tap_rti    = tap_ctrl.rti;

endmodule

//--- verilog/stap_dr.sv
/*
 * Generic data register
 * Parallel capture, serial shift toward bit 0, parallel update
 */

module stap_dr #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     ftap_tck,
    input  logic     rst_n,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    input  logic     ftap_tdi,
    input  payload_t capture_data,
    output logic     shift_tdo,
    output payload_t update_data
);

    localparam int width = $bits(payload_t);

    payload_t shift_q;

    // ------------------------------
    // Shift stage
    // ------------------------------
    // Capture wins over shift, strobes are exclusive anyway
    always_ff @(posedge ftap_tck) begin
        if (capture) begin
            shift_q <= capture_data;
        end else if (shift) begin
            shift_q <= payload_t'({ftap_tdi, shift_q[width-1:1]});
        end
    end

    // LSB leaves first
    assign shift_tdo = shift_q[0];

    // ------------------------------
    // Update stage
    // ------------------------------
    // Parallel output only moves on update
    always_ff @(posedge ftap_tck) begin
        if (!rst_n) begin
            update_data <= '0;
        end else if (update) begin
            update_data <= shift_q;
        end
    end

    // Gated strobes from the controller stay exclusive
    a_strobe_excl: assert property (@(posedge ftap_tck) disable iff (!rst_n)
        $onehot0({capture, shift, update}))
        else $error("DR strobes overlap");

endmodule

//--- verilog/stap_fsm.sv
/*
 * TAP controller
 * Sixteen-state 1149.1 state graph driven by TMS
 * State decode into the control strobe struct
 */

module stap_fsm
    import stap_pkg::*;
(
    input  logic      ftap_tck,
    input  logic      rst_n,
    input  logic      ftap_tms,
    output tap_ctrl_t tap_ctrl
);

    tap_state_e state_q;
    tap_state_e state_d;

    // ------------------------------
    // Next state
    // ------------------------------
    // Standard graph, TMS picks one of two successors
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_tlr:      state_d = ftap_tms ? st_tlr      : st_rti;
            st_rti:      state_d = ftap_tms ? st_sel_dr   : st_rti;
            st_sel_dr:   state_d = ftap_tms ? st_sel_ir   : st_cap_dr;
            st_cap_dr:   state_d = ftap_tms ? st_exit1_dr : st_shift_dr;
            st_shift_dr: state_d = ftap_tms ? st_exit1_dr : st_shift_dr;
            st_exit1_dr: state_d = ftap_tms ? st_upd_dr   : st_pause_dr;
            st_pause_dr: state_d = ftap_tms ? st_exit2_dr : st_pause_dr;
            st_exit2_dr: state_d = ftap_tms ? st_upd_dr   : st_shift_dr;
            st_upd_dr:   state_d = ftap_tms ? st_sel_dr   : st_rti;
            st_sel_ir:   state_d = ftap_tms ? st_tlr      : st_cap_ir;
            st_cap_ir:   state_d = ftap_tms ? st_exit1_ir : st_shift_ir;
            st_shift_ir: state_d = ftap_tms ? st_exit1_ir : st_shift_ir;
            st_exit1_ir: state_d = ftap_tms ? st_upd_ir   : st_pause_ir;
            st_pause_ir: state_d = ftap_tms ? st_exit2_ir : st_pause_ir;
            st_exit2_ir: state_d = ftap_tms ? st_upd_ir   : st_shift_ir;
            st_upd_ir:   state_d = ftap_tms ? st_sel_dr   : st_rti;
            default:     state_d = st_tlr;
        endcase
    end

    // State register
    always_ff @(posedge ftap_tck) begin
        if (!rst_n) begin
            state_q <= st_tlr;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // Strobe decode
    // ------------------------------
    // Pure decode of the current state
    always_comb begin
        tap_ctrl.tlr        = (state_q == st_tlr);
        tap_ctrl.rti        = (state_q == st_rti);
        tap_ctrl.capture_ir = (state_q == st_cap_ir);
        tap_ctrl.shift_ir   = (state_q == st_shift_ir);
        tap_ctrl.update_ir  = (state_q == st_upd_ir);
        tap_ctrl.capture_dr = (state_q == st_cap_dr);
        tap_ctrl.shift_dr   = (state_q == st_shift_dr);
        tap_ctrl.update_dr  = (state_q == st_upd_dr);
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    // Register operations never overlap, IR and DR alike
    a_one_op: assert property (@(posedge ftap_tck) disable iff (!rst_n)
        $onehot0({tap_ctrl.capture_ir, tap_ctrl.shift_ir, tap_ctrl.update_ir,
                  tap_ctrl.capture_dr, tap_ctrl.shift_dr, tap_ctrl.update_dr}))
        else $error("TAP strobes overlap");

    // Five TMS-high edges reach Test-Logic-Reset from any state
    a_tms_reset: assert property (@(posedge ftap_tck) disable iff (!rst_n)
        ftap_tms [*5] |=> tap_ctrl.tlr)
        else $error("Five TMS-high edges did not reach Test-Logic-Reset");

endmodule

//--- verilog/stap_ir.sv
/*
 * Instruction register
 * Capture/shift stage, latched instruction and DR select decode
 */

module stap_ir
    import stap_pkg::*;
(
    input  logic      ftap_tck,
    input  logic      rst_n,
    input  tap_ctrl_t tap_ctrl,
    input  logic      ftap_tdi,
    output logic      ir_tdo,
    output dr_sel_t   dr_sel
);

    logic [ir_width-1:0] ir_shift;
    tap_opcode_e         ir_active;

    // ------------------------------
    // Shift stage
    // ------------------------------
    // Loads the fixed pattern, then shifts right, TDI in at the MSB
    always_ff @(posedge ftap_tck) begin
        if (tap_ctrl.capture_ir) begin
            ir_shift <= ir_capture_value;
        end else if (tap_ctrl.shift_ir) begin
            ir_shift <= {ftap_tdi, ir_shift[ir_width-1:1]};
        end
    end

    assign ir_tdo = ir_shift[0];

    // Active instruction falls back to IDCODE out of reset and in Test-Logic-Reset
    always_ff @(posedge ftap_tck) begin
        if (!rst_n || tap_ctrl.tlr) begin
            ir_active <= op_idcode;
        end else if (tap_ctrl.update_ir) begin
            ir_active <= tap_opcode_e'(ir_shift);
        end
    end

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        dr_sel = '0;
        case (ir_active)
            op_idcode: dr_sel.sel_idcode = 1'b1;
            op_tdr:    dr_sel.sel_tdr    = 1'b1;
            op_bypass: dr_sel.sel_bypass = 1'b1;
            // Undefined opcodes
            default:   dr_sel.sel_bypass = 1'b1;
        endcase
    end

    // Exactly one data register is selected
    a_sel_onehot: assert property (@(posedge ftap_tck) disable iff (!rst_n)
        $onehot(dr_sel))
        else $error("DR select is not one-hot");

endmodule

//--- verilog/stap_pkg.sv
/*
 * Shared definitions for the TAP
 * Width localparams and IR capture pattern
 * TAP state and opcode enums, control strobe and DR select structs
 */

package stap_pkg;

    // ------------------------------
    // Widths and constants
    // ------------------------------
    localparam int ir_width     = 4;
    localparam int idcode_width = 32;
    localparam int tdr_width    = 16;

    // Low two bits give the mandatory 01 pattern
    localparam logic [ir_width-1:0] ir_capture_value = 4'b0001;

    // ------------------------------
    // Types
    // ------------------------------
    // Sixteen controller states
    typedef enum logic [3:0] {
        st_tlr      = 4'h0,
        st_rti      = 4'h1,
        st_sel_dr   = 4'h2,
        st_cap_dr   = 4'h3,
        st_shift_dr = 4'h4,
        st_exit1_dr = 4'h5,
        st_pause_dr = 4'h6,
        st_exit2_dr = 4'h7,
        st_upd_dr   = 4'h8,
        st_sel_ir   = 4'h9,
        st_cap_ir   = 4'ha,
        st_shift_ir = 4'hb,
        st_exit1_ir = 4'hc,
        st_pause_ir = 4'hd,
        st_exit2_ir = 4'he,
        st_upd_ir   = 4'hf
    } tap_state_e;

    // Undefined opcodes behave as BYPASS
    typedef enum logic [ir_width-1:0] {
        op_idcode = 4'd1,
        op_tdr    = 4'd2,
        op_bypass = 4'd15
    } tap_opcode_e;

    // One field per state of interest, high while in that state
    typedef struct packed {
        logic tlr;
        logic rti;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
    } tap_ctrl_t;

    // Selected data register, one-hot
    typedef struct packed {
        logic sel_idcode;
        logic sel_tdr;
        logic sel_bypass;
    } dr_sel_t;

    typedef logic [idcode_width-1:0] idcode_t;
    typedef logic [tdr_width-1:0]    tdr_t;

endpackage
